// File: vc_pkg.sv
// cache tile shared definitions
// sizes, opcodes, wormhole header layout and credit depths
package vc_pkg;

  localparam int VC_WORD_W      = 32;
  localparam int VC_ADDR_W      = 10;
  localparam int VC_BLOCK_WORDS = 4;
  localparam int VC_SETS        = 8;
  localparam int VC_OFS_W       = $clog2(VC_BLOCK_WORDS);
  localparam int VC_IDX_W       = $clog2(VC_SETS);
  localparam int VC_TAG_W       = VC_ADDR_W - VC_IDX_W - VC_OFS_W;
  localparam int VC_BADDR_W     = VC_ADDR_W - VC_OFS_W;
  localparam int VC_SRC_W       = 4;

  // one row of routers, a memory controller at each end
  localparam int VC_CORD_W = 4;
  localparam logic [VC_CORD_W-1:0] VC_MEM_W_CORD = 4'd0;
  localparam logic [VC_CORD_W-1:0] VC_MEM_E_CORD = 4'd15;
  localparam int VC_FLIT_W = 36;

  // header flit fields
  localparam int VC_HDR_DEST_POS  = 0;
  localparam int VC_HDR_DEST_W    = VC_CORD_W;
  localparam int VC_HDR_LEN_POS   = 4;
  localparam int VC_HDR_LEN_W     = 3;
  localparam int VC_HDR_OP_POS    = 7;
  localparam int VC_HDR_OP_W      = 1;
  localparam int VC_HDR_SRC_POS   = 8;
  localparam int VC_HDR_SRC_W     = VC_CORD_W;
  localparam int VC_HDR_BADDR_POS = 12;
  localparam int VC_HDR_BADDR_W   = VC_BADDR_W;

  // router port index
  localparam int VC_DIR_P = 0;
  localparam int VC_DIR_W = 1;
  localparam int VC_DIR_E = 2;

  localparam int VC_LINK_CREDITS = 4;
  localparam int VC_WH_CREDITS   = 4;
  localparam int VC_LINK_CRED_W  = $clog2(VC_LINK_CREDITS + 1);
  localparam int VC_WH_CRED_W    = $clog2(VC_WH_CREDITS + 1);

  typedef enum logic {VC_OP_LOAD = 1'b0, VC_OP_STORE = 1'b1} vc_op_e;
  typedef enum logic {VC_DMA_FILL = 1'b0, VC_DMA_WB = 1'b1} vc_dma_op_e;

  typedef struct packed {
    vc_op_e               op;
    logic [VC_ADDR_W-1:0] addr;
    logic [VC_WORD_W-1:0] data;
    logic [VC_SRC_W-1:0]  src;
  } vc_req_t;

endpackage

// File: vc_credit_fifo.sv
// credit FIFO
// circular buffer that returns one credit for every dequeued entry
`timescale 1ns/100ps

module vc_credit_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output logic     valid_o,
  output payload_t data_o,
  output logic     credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0] count_q;
  logic deq;

  assign deq      = pop_i & valid_o;
  assign valid_o  = (count_q != '0);
  assign data_o   = mem[rd_ptr_q];
  // credit goes back as the head leaves
  assign credit_o = deq;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      if (deq) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(deq);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem[wr_ptr_q] <= data_i;
  end

endmodule

// File: vc_link_to_cache.sv
// link to cache adapter
// buffers link requests for the cache and returns responses under credits
`timescale 1ns/100ps

module vc_link_to_cache (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         req_v_i,
  input  vc_pkg::vc_op_e               req_op_i,
  input  logic [vc_pkg::VC_ADDR_W-1:0] req_addr_i,
  input  logic [vc_pkg::VC_WORD_W-1:0] req_data_i,
  input  logic [vc_pkg::VC_SRC_W-1:0]  req_src_i,
  output logic                         req_credit_o,
  output logic                         resp_v_o,
  output vc_pkg::vc_op_e               resp_op_o,
  output logic [vc_pkg::VC_WORD_W-1:0] resp_data_o,
  output logic [vc_pkg::VC_SRC_W-1:0]  resp_src_o,
  input  logic                         resp_credit_i,
  output logic                         cache_req_v_o,
  output vc_pkg::vc_req_t              cache_req_o,
  input  logic                         cache_req_ready_i,
  input  logic                         cache_resp_v_i,
  input  logic [vc_pkg::VC_WORD_W-1:0] cache_resp_data_i,
  output logic                         cache_resp_ready_o
);
  import vc_pkg::*;

  vc_req_t req_in;
  vc_op_e svc_op_q;
  logic [VC_SRC_W-1:0] svc_src_q;
  logic [VC_LINK_CRED_W-1:0] cred_q;
  logic resp_take;

  assign req_in = '{op: req_op_i, addr: req_addr_i, data: req_data_i, src: req_src_i};

  vc_credit_fifo #(
    .payload_t(vc_req_t),
    .DEPTH(VC_LINK_CREDITS)
  ) req_fifo (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .push_i(req_v_i),
    .data_i(req_in),
    .pop_i(cache_req_ready_i),
    .valid_o(cache_req_v_o),
    .data_o(cache_req_o),
    .credit_o(req_credit_o)
  );

  // a response is only taken when the far side has room for it
  assign cache_resp_ready_o = (cred_q != '0);
  assign resp_take = cache_resp_v_i & cache_resp_ready_o;

  always_ff @(posedge clk_i) begin
    if (cache_req_v_o & cache_req_ready_i) begin
      svc_op_q  <= cache_req_o.op;
      svc_src_q <= cache_req_o.src;
    end
    if (resp_take) begin
      resp_op_o   <= svc_op_q;
      resp_src_o  <= svc_src_q;
      resp_data_o <= (svc_op_q == VC_OP_STORE) ? '0 : cache_resp_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_v_o <= 1'b0;
      cred_q   <= VC_LINK_CRED_W'(VC_LINK_CREDITS);
    end else begin
      resp_v_o <= resp_take;
      cred_q   <= cred_q - VC_LINK_CRED_W'(resp_take) + VC_LINK_CRED_W'(resp_credit_i);
    end
  end

endmodule

// File: vc_cache.sv
// direct-mapped write-back cache
// write-allocate, dirty victims go out over DMA before the block fill
`timescale 1ns/100ps

module vc_cache (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          req_v_i,
  input  vc_pkg::vc_req_t               req_i,
  output logic                          req_ready_o,
  output logic                          resp_v_o,
  output logic [vc_pkg::VC_WORD_W-1:0]  resp_data_o,
  input  logic                          resp_ready_i,
  output logic                          dma_cmd_v_o,
  output vc_pkg::vc_dma_op_e            dma_cmd_op_o,
  output logic [vc_pkg::VC_BADDR_W-1:0] dma_cmd_addr_o,
  input  logic                          dma_cmd_ready_i,
  output logic                          dma_wdata_v_o,
  output logic [vc_pkg::VC_WORD_W-1:0]  dma_wdata_o,
  input  logic                          dma_wdata_ready_i,
  input  logic                          dma_rdata_v_i,
  input  logic [vc_pkg::VC_WORD_W-1:0]  dma_rdata_i,
  output logic                          dma_rdata_ready_o
);
  import vc_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, S_LOOKUP, S_WB_CMD, S_WB_DATA, S_FILL_CMD, S_FILL_DATA
  } state_e;

  state_e state_q, state_d;
  vc_req_t req_q;
  logic [VC_TAG_W-1:0] tag_mem [VC_SETS];
  logic [VC_WORD_W-1:0] data_mem [VC_SETS][VC_BLOCK_WORDS];
  logic [VC_SETS-1:0] valid_q, dirty_q;
  logic [VC_OFS_W-1:0] cnt_q;
  logic [VC_TAG_W-1:0] tag;
  logic [VC_IDX_W-1:0] idx;
  logic [VC_OFS_W-1:0] ofs;
  logic hit, last_word, store_hit, wb_beat, fill_beat;

  assign {tag, idx, ofs} = req_q.addr;
  assign hit       = valid_q[idx] & (tag_mem[idx] == tag);
  assign last_word = (cnt_q == VC_OFS_W'(VC_BLOCK_WORDS-1));

  assign req_ready_o = (state_q == S_IDLE);
  // hit answers straight from the lookup cycle
  assign resp_v_o    = (state_q == S_LOOKUP) & hit;
  assign resp_data_o = data_mem[idx][ofs];
  assign store_hit   = resp_v_o & resp_ready_i & (req_q.op == VC_OP_STORE);

  assign dma_cmd_v_o    = (state_q == S_WB_CMD) | (state_q == S_FILL_CMD);
  assign dma_cmd_op_o   = (state_q == S_WB_CMD) ? VC_DMA_WB : VC_DMA_FILL;
  // victim block address is rebuilt from the stored tag
  assign dma_cmd_addr_o = (state_q == S_WB_CMD) ? {tag_mem[idx], idx} : {tag, idx};

  assign dma_wdata_v_o     = (state_q == S_WB_DATA);
  assign dma_wdata_o       = data_mem[idx][cnt_q];
  assign dma_rdata_ready_o = (state_q == S_FILL_DATA);
  assign wb_beat   = dma_wdata_v_o & dma_wdata_ready_i;
  assign fill_beat = dma_rdata_ready_o & dma_rdata_v_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: if (req_v_i) state_d = S_LOOKUP;
      S_LOOKUP: begin
        if (hit) begin
          if (resp_ready_i) state_d = S_IDLE;
        end else if (valid_q[idx] & dirty_q[idx]) begin
          state_d = S_WB_CMD;
        end else begin
          state_d = S_FILL_CMD;
        end
      end
      S_WB_CMD:    if (dma_cmd_ready_i) state_d = S_WB_DATA;
      S_WB_DATA:   if (wb_beat & last_word) state_d = S_FILL_CMD;
      S_FILL_CMD:  if (dma_cmd_ready_i) state_d = S_FILL_DATA;
      // replay the access once the block is in
      S_FILL_DATA: if (fill_beat & last_word) state_d = S_LOOKUP;
      default:     state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      state_q <= state_d;
      // word counter wraps back to zero after each block
      if (wb_beat | fill_beat) cnt_q <= cnt_q + 1'b1;
      if (fill_beat & last_word) begin
        valid_q[idx] <= 1'b1;
        dirty_q[idx] <= 1'b0;
      end
      if (store_hit) dirty_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i & req_ready_o) req_q <= req_i;
    if (fill_beat) data_mem[idx][cnt_q] <= dma_rdata_i;
    if (fill_beat & last_word) tag_mem[idx] <= tag;
    if (store_hit) data_mem[idx][ofs] <= req_q.data;
  end

endmodule

// File: vc_dma_to_wormhole.sv
// cache DMA to wormhole adapter
// packs fill and writeback commands into packets, unpacks fill replies
`timescale 1ns/100ps

module vc_dma_to_wormhole (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic [vc_pkg::VC_CORD_W-1:0]  my_cord_i,
  input  logic                          dma_cmd_v_i,
  input  vc_pkg::vc_dma_op_e            dma_cmd_op_i,
  input  logic [vc_pkg::VC_BADDR_W-1:0] dma_cmd_addr_i,
  output logic                          dma_cmd_ready_o,
  input  logic                          dma_wdata_v_i,
  input  logic [vc_pkg::VC_WORD_W-1:0]  dma_wdata_i,
  output logic                          dma_wdata_ready_o,
  output logic                          dma_rdata_v_o,
  output logic [vc_pkg::VC_WORD_W-1:0]  dma_rdata_o,
  input  logic                          dma_rdata_ready_i,
  output logic                          flit_v_o,
  output logic [vc_pkg::VC_FLIT_W-1:0]  flit_o,
  input  logic                          flit_ready_i,
  input  logic                          flit_v_i,
  input  logic [vc_pkg::VC_FLIT_W-1:0]  flit_i,
  output logic                          flit_ready_o
);
  import vc_pkg::*;

  logic [VC_HDR_LEN_W-1:0] tx_left_q, rx_left_q;
  logic [VC_FLIT_W-1:0] hdr;
  logic tx_body, rx_body;

  assign tx_body = (tx_left_q != '0);
  assign rx_body = (rx_left_q != '0);

  // top address bit picks the memory at the east or west end
  always_comb begin
    hdr = '0;
    hdr[VC_HDR_DEST_POS +: VC_HDR_DEST_W] =
      dma_cmd_addr_i[VC_BADDR_W-1] ? VC_MEM_E_CORD : VC_MEM_W_CORD;
    hdr[VC_HDR_LEN_POS +: VC_HDR_LEN_W] =
      (dma_cmd_op_i == VC_DMA_WB) ? VC_HDR_LEN_W'(VC_BLOCK_WORDS) : '0;
    hdr[VC_HDR_OP_POS +: VC_HDR_OP_W]       = dma_cmd_op_i;
    hdr[VC_HDR_SRC_POS +: VC_HDR_SRC_W]     = my_cord_i;
    hdr[VC_HDR_BADDR_POS +: VC_HDR_BADDR_W] = dma_cmd_addr_i;
  end

  // header first, then the writeback words
  assign flit_v_o          = tx_body ? dma_wdata_v_i : dma_cmd_v_i;
  assign flit_o            = tx_body ? VC_FLIT_W'(dma_wdata_i) : hdr;
  assign dma_cmd_ready_o   = ~tx_body & flit_ready_i;
  assign dma_wdata_ready_o = tx_body & flit_ready_i;

  // reply header stops here, only the words reach the cache
  assign dma_rdata_v_o = rx_body & flit_v_i;
  assign dma_rdata_o   = flit_i[VC_WORD_W-1:0];
  assign flit_ready_o  = ~rx_body | dma_rdata_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_left_q <= '0;
      rx_left_q <= '0;
    end else begin
      if (dma_cmd_v_i & dma_cmd_ready_o & (dma_cmd_op_i == VC_DMA_WB)) begin
        tx_left_q <= VC_HDR_LEN_W'(VC_BLOCK_WORDS);
      end else if (dma_wdata_v_i & dma_wdata_ready_o) begin
        tx_left_q <= tx_left_q - 1'b1;
      end
      if (flit_v_i & flit_ready_o) begin
        rx_left_q <= rx_body ? rx_left_q - 1'b1 : flit_i[VC_HDR_LEN_POS +: VC_HDR_LEN_W];
      end
    end
  end

endmodule

// File: vc_wh_router.sv
// one-dimensional wormhole router with P, W and E ports
// credits on W and E, valid/ready on P, outputs locked per packet
`timescale 1ns/100ps

module vc_wh_router (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic [vc_pkg::VC_CORD_W-1:0] my_cord_i,
  input  logic                         p_v_i,
  input  logic [vc_pkg::VC_FLIT_W-1:0] p_flit_i,
  output logic                         p_ready_o,
  output logic                         p_v_o,
  output logic [vc_pkg::VC_FLIT_W-1:0] p_flit_o,
  input  logic                         p_ready_i,
  input  logic                         w_v_i,
  input  logic [vc_pkg::VC_FLIT_W-1:0] w_flit_i,
  output logic                         w_credit_o,
  output logic                         w_v_o,
  output logic [vc_pkg::VC_FLIT_W-1:0] w_flit_o,
  input  logic                         w_credit_i,
  input  logic                         e_v_i,
  input  logic [vc_pkg::VC_FLIT_W-1:0] e_flit_i,
  output logic                         e_credit_o,
  output logic                         e_v_o,
  output logic [vc_pkg::VC_FLIT_W-1:0] e_flit_o,
  input  logic                         e_credit_i
);
  import vc_pkg::*;

  logic [2:0] in_v, pop, out_can, out_v_q;
  logic [VC_FLIT_W-1:0] in_flit [3];
  logic [VC_FLIT_W-1:0] out_flit_q [3];
  logic [1:0] req_dir [3];
  logic [1:0] in_dir_q [3];
  logic [1:0] rr_q [3];
  logic [VC_HDR_LEN_W-1:0] in_left_q [3];
  // gnt[output][input]
  logic [2:0] gnt [3];
  logic [VC_WH_CRED_W-1:0] cred_q [VC_DIR_W:VC_DIR_E];
  logic [VC_DIR_E:VC_DIR_W] out_credit;

  vc_credit_fifo #(.payload_t(logic [VC_FLIT_W-1:0]), .DEPTH(VC_WH_CREDITS)) w_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .push_i(w_v_i), .data_i(w_flit_i), .pop_i(pop[VC_DIR_W]),
    .valid_o(in_v[VC_DIR_W]), .data_o(in_flit[VC_DIR_W]), .credit_o(w_credit_o)
  );

  vc_credit_fifo #(.payload_t(logic [VC_FLIT_W-1:0]), .DEPTH(VC_WH_CREDITS)) e_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .push_i(e_v_i), .data_i(e_flit_i), .pop_i(pop[VC_DIR_E]),
    .valid_o(in_v[VC_DIR_E]), .data_o(in_flit[VC_DIR_E]), .credit_o(e_credit_o)
  );

  assign in_v[VC_DIR_P]    = p_v_i;
  assign in_flit[VC_DIR_P] = p_flit_i;
  assign p_ready_o         = pop[VC_DIR_P];
  assign pop        = gnt[VC_DIR_P] | gnt[VC_DIR_W] | gnt[VC_DIR_E];
  assign out_credit = {e_credit_i, w_credit_i};

  assign out_can[VC_DIR_P] = ~out_v_q[VC_DIR_P] | p_ready_i;
  assign out_can[VC_DIR_W] = (cred_q[VC_DIR_W] != '0);
  assign out_can[VC_DIR_E] = (cred_q[VC_DIR_E] != '0);

  // body flits follow the header's route
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      if (in_left_q[i] != '0) req_dir[i] = in_dir_q[i];
      else if (in_flit[i][VC_HDR_DEST_POS +: VC_HDR_DEST_W] < my_cord_i) req_dir[i] = 2'(VC_DIR_W);
      else if (in_flit[i][VC_HDR_DEST_POS +: VC_HDR_DEST_W] > my_cord_i) req_dir[i] = 2'(VC_DIR_E);
      else req_dir[i] = 2'(VC_DIR_P);
    end
  end

  always_comb begin
    logic busy;
    int k;
    for (int o = 0; o < 3; o++) begin
      gnt[o] = '0;
      busy = 1'b0;
      for (int i = 0; i < 3; i++) begin
        if (in_left_q[i] != '0 && in_dir_q[i] == 2'(o)) begin
          busy = 1'b1;
          gnt[o][i] = in_v[i] & out_can[o];
        end
      end
      // free output, headers take turns after the last winner
      for (int j = 1; j <= 3; j++) begin
        k = (int'(rr_q[o]) + j) % 3;
        if (!busy && out_can[o] && in_v[k] && req_dir[k] == 2'(o) && gnt[o] == '0) begin
          gnt[o][k] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_v_q <= '0;
      for (int i = 0; i < 3; i++) begin
        in_left_q[i] <= '0;
        rr_q[i]      <= '0;
      end
      cred_q[VC_DIR_W] <= VC_WH_CRED_W'(VC_WH_CREDITS);
      cred_q[VC_DIR_E] <= VC_WH_CRED_W'(VC_WH_CREDITS);
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (pop[i]) begin
          in_left_q[i] <= (in_left_q[i] != '0) ? in_left_q[i] - 1'b1
                                               : in_flit[i][VC_HDR_LEN_POS +: VC_HDR_LEN_W];
        end
      end
      for (int o = 0; o < 3; o++) begin
        if (gnt[o] != '0) out_v_q[o] <= 1'b1;
        else if (o != VC_DIR_P || p_ready_i) out_v_q[o] <= 1'b0;
        for (int i = 0; i < 3; i++) begin
          if (gnt[o][i] && in_left_q[i] == '0) rr_q[o] <= 2'(i);
        end
      end
      for (int o = VC_DIR_W; o <= VC_DIR_E; o++) begin
        cred_q[o] <= cred_q[o] - VC_WH_CRED_W'(gnt[o] != '0) + VC_WH_CRED_W'(out_credit[o]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 3; i++) begin
      if (pop[i] && in_left_q[i] == '0) in_dir_q[i] <= req_dir[i];
    end
    for (int o = 0; o < 3; o++) begin
      for (int i = 0; i < 3; i++) begin
        if (gnt[o][i]) out_flit_q[o] <= in_flit[i];
      end
    end
  end

  assign p_v_o    = out_v_q[VC_DIR_P];
  assign p_flit_o = out_flit_q[VC_DIR_P];
  assign w_v_o    = out_v_q[VC_DIR_W];
  assign w_flit_o = out_flit_q[VC_DIR_W];
  assign e_v_o    = out_v_q[VC_DIR_E];
  assign e_flit_o = out_flit_q[VC_DIR_E];

endmodule

// File: vc_tile.sv
// cache tile top level
// link adapter, cache, DMA to wormhole adapter and row router
`timescale 1ns/100ps

module vc_tile (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic [vc_pkg::VC_CORD_W-1:0] my_cord_i,
  input  logic                         req_v_i,
  input  vc_pkg::vc_op_e               req_op_i,
  input  logic [vc_pkg::VC_ADDR_W-1:0] req_addr_i,
  input  logic [vc_pkg::VC_WORD_W-1:0] req_data_i,
  input  logic [vc_pkg::VC_SRC_W-1:0]  req_src_i,
  output logic                         req_credit_o,
  output logic                         resp_v_o,
  output vc_pkg::vc_op_e               resp_op_o,
  output logic [vc_pkg::VC_WORD_W-1:0] resp_data_o,
  output logic [vc_pkg::VC_SRC_W-1:0]  resp_src_o,
  input  logic                         resp_credit_i,
  output logic                         wh_w_v_o,
  output logic [vc_pkg::VC_FLIT_W-1:0] wh_w_flit_o,
  input  logic                         wh_w_credit_i,
  input  logic                         wh_w_v_i,
  input  logic [vc_pkg::VC_FLIT_W-1:0] wh_w_flit_i,
  output logic                         wh_w_credit_o,
  output logic                         wh_e_v_o,
  output logic [vc_pkg::VC_FLIT_W-1:0] wh_e_flit_o,
  input  logic                         wh_e_credit_i,
  input  logic                         wh_e_v_i,
  input  logic [vc_pkg::VC_FLIT_W-1:0] wh_e_flit_i,
  output logic                         wh_e_credit_o
);
  import vc_pkg::*;

  vc_req_t cache_req;
  logic cache_req_v, cache_req_ready, cache_resp_v, cache_resp_ready;
  logic [VC_WORD_W-1:0] cache_resp_data, dma_wdata, dma_rdata;
  logic dma_cmd_v, dma_cmd_ready, dma_wdata_v, dma_wdata_ready, dma_rdata_v, dma_rdata_ready;
  vc_dma_op_e dma_cmd_op;
  logic [VC_BADDR_W-1:0] dma_cmd_addr;
  // DMA adapter to router P port
  logic p_in_v, p_in_ready, p_out_v, p_out_ready;
  logic [VC_FLIT_W-1:0] p_in_flit, p_out_flit;

  vc_link_to_cache link_to_cache (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .req_v_i(req_v_i), .req_op_i(req_op_i), .req_addr_i(req_addr_i),
    .req_data_i(req_data_i), .req_src_i(req_src_i), .req_credit_o(req_credit_o),
    .resp_v_o(resp_v_o), .resp_op_o(resp_op_o), .resp_data_o(resp_data_o),
    .resp_src_o(resp_src_o), .resp_credit_i(resp_credit_i),
    .cache_req_v_o(cache_req_v), .cache_req_o(cache_req), .cache_req_ready_i(cache_req_ready),
    .cache_resp_v_i(cache_resp_v), .cache_resp_data_i(cache_resp_data),
    .cache_resp_ready_o(cache_resp_ready)
  );

  vc_cache cache (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .req_v_i(cache_req_v), .req_i(cache_req), .req_ready_o(cache_req_ready),
    .resp_v_o(cache_resp_v), .resp_data_o(cache_resp_data), .resp_ready_i(cache_resp_ready),
    .dma_cmd_v_o(dma_cmd_v), .dma_cmd_op_o(dma_cmd_op), .dma_cmd_addr_o(dma_cmd_addr),
    .dma_cmd_ready_i(dma_cmd_ready),
    .dma_wdata_v_o(dma_wdata_v), .dma_wdata_o(dma_wdata), .dma_wdata_ready_i(dma_wdata_ready),
    .dma_rdata_v_i(dma_rdata_v), .dma_rdata_i(dma_rdata), .dma_rdata_ready_o(dma_rdata_ready)
  );

  vc_dma_to_wormhole dma_to_wh (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .my_cord_i(my_cord_i),
    .dma_cmd_v_i(dma_cmd_v), .dma_cmd_op_i(dma_cmd_op), .dma_cmd_addr_i(dma_cmd_addr),
    .dma_cmd_ready_o(dma_cmd_ready),
    .dma_wdata_v_i(dma_wdata_v), .dma_wdata_i(dma_wdata), .dma_wdata_ready_o(dma_wdata_ready),
    .dma_rdata_v_o(dma_rdata_v), .dma_rdata_o(dma_rdata), .dma_rdata_ready_i(dma_rdata_ready),
    .flit_v_o(p_in_v), .flit_o(p_in_flit), .flit_ready_i(p_in_ready),
    .flit_v_i(p_out_v), .flit_i(p_out_flit), .flit_ready_o(p_out_ready)
  );

  vc_wh_router wh_rtr (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .my_cord_i(my_cord_i),
    .p_v_i(p_in_v), .p_flit_i(p_in_flit), .p_ready_o(p_in_ready),
    .p_v_o(p_out_v), .p_flit_o(p_out_flit), .p_ready_i(p_out_ready),
    .w_v_i(wh_w_v_i), .w_flit_i(wh_w_flit_i), .w_credit_o(wh_w_credit_o),
    .w_v_o(wh_w_v_o), .w_flit_o(wh_w_flit_o), .w_credit_i(wh_w_credit_i),
    .e_v_i(wh_e_v_i), .e_flit_i(wh_e_flit_i), .e_credit_o(wh_e_credit_o),
    .e_v_o(wh_e_v_o), .e_flit_o(wh_e_flit_o), .e_credit_i(wh_e_credit_i)
  );

endmodule

// File: tb_vc_mem.sv
// testbench memory controller at one end of the wormhole row
// serves block fills, absorbs writebacks, credit flow control both ways
`timescale 1ns/100ps

module tb_vc_mem #(
  parameter logic [3:0] MY_CORD = 4'd0,
  parameter bit         IS_EAST = 1'b0
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        v_i,
  input  logic [35:0] flit_i,
  output logic        credit_o,
  output logic        v_o,
  output logic [35:0] flit_o,
  input  logic        credit_i,
  output logic        err_o
);
  import vc_pkg::*;

  logic [VC_WORD_W-1:0] mem [1024];
  logic [VC_FLIT_W-1:0] tx_q [$];
  logic [VC_FLIT_W-1:0] hdr;
  logic [VC_BADDR_W-1:0] baddr, wb_baddr;
  logic [VC_HDR_LEN_W-1:0] len;
  logic [1:0] wb_cnt;
  int cred;
  int rx_left;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_o <= 1'b0;
      v_o      <= 1'b0;
      flit_o   <= '0;
      err_o    <= 1'b0;
      cred     = VC_WH_CREDITS;
      rx_left  = 0;
      wb_cnt   = '0;
      tx_q.delete();
      // known contents that depend on the whole word address
      for (int a = 0; a < 1024; a++) begin
        mem[a] = {16'hc0de, 6'd0, 10'(a)};
      end
    end else begin
      // every flit is consumed at once, so its buffer slot frees right away
      credit_o <= v_i;
      cred = cred + int'(credit_i);
      if (v_i) begin
        if (rx_left == 0) begin
          baddr = flit_i[VC_HDR_BADDR_POS +: VC_HDR_BADDR_W];
          len   = flit_i[VC_HDR_LEN_POS +: VC_HDR_LEN_W];
          if (baddr[VC_BADDR_W-1] != IS_EAST) begin
            $display("memory at %0d got a header for block %h of the other side", MY_CORD, baddr);
            err_o <= 1'b1;
          end
          if (len == '0) begin
            // fill reply goes back to the requesting tile
            hdr = '0;
            hdr[VC_HDR_DEST_POS +: VC_HDR_DEST_W]   = flit_i[VC_HDR_SRC_POS +: VC_HDR_SRC_W];
            hdr[VC_HDR_LEN_POS +: VC_HDR_LEN_W]     = VC_HDR_LEN_W'(VC_BLOCK_WORDS);
            hdr[VC_HDR_OP_POS +: VC_HDR_OP_W]       = VC_DMA_FILL;
            hdr[VC_HDR_SRC_POS +: VC_HDR_SRC_W]     = MY_CORD;
            hdr[VC_HDR_BADDR_POS +: VC_HDR_BADDR_W] = baddr;
            tx_q.push_back(hdr);
            for (int k = 0; k < VC_BLOCK_WORDS; k++) begin
              tx_q.push_back(VC_FLIT_W'(mem[{baddr, 2'(k)}]));
            end
          end else begin
            rx_left  = int'(len);
            wb_baddr = baddr;
            wb_cnt   = '0;
          end
        end else begin
          mem[{wb_baddr, wb_cnt}] = flit_i[VC_WORD_W-1:0];
          wb_cnt  = wb_cnt + 2'd1;
          rx_left = rx_left - 1;
        end
      end
      if (tx_q.size() > 0 && cred > 0) begin
        v_o    <= 1'b1;
        flit_o <= tx_q.pop_front();
        cred   = cred - 1;
      end else begin
        v_o <= 1'b0;
      end
      if (cred < 0 || cred > VC_WH_CREDITS) begin
        $display("memory at %0d credit count out of range: %0d", MY_CORD, cred);
        err_o <= 1'b1;
      end
    end
  end

endmodule

// File: tb_vc_tile.sv
// testbench for the cache tile
// drives the request link, checks responses against a reference memory
`timescale 1ns/100ps

module tb_vc_tile;
  import vc_pkg::*;

  localparam int N_REQ     = 215;
  localparam int WDOG_CYC  = N_REQ * 200 + 1000;

  typedef struct {
    vc_op_e               op;
    logic [VC_SRC_W-1:0]  src;
    logic [VC_WORD_W-1:0] data;
  } exp_t;

  logic clk_i;
  logic arst_n_i;
  logic req_v_i;
  vc_op_e req_op_i;
  logic [VC_ADDR_W-1:0] req_addr_i;
  logic [VC_WORD_W-1:0] req_data_i;
  logic [VC_SRC_W-1:0] req_src_i;
  logic req_credit_o, resp_v_o;
  vc_op_e resp_op_o;
  logic [VC_WORD_W-1:0] resp_data_o;
  logic [VC_SRC_W-1:0] resp_src_o;
  logic resp_credit_i = 1'b0;
  logic wh_w_v_o, wh_w_credit_i, wh_w_v_i, wh_w_credit_o;
  logic wh_e_v_o, wh_e_credit_i, wh_e_v_i, wh_e_credit_o;
  logic [VC_FLIT_W-1:0] wh_w_flit_o, wh_w_flit_i, wh_e_flit_o, wh_e_flit_i;
  logic mem_w_err, mem_e_err;

  logic [VC_WORD_W-1:0] ref_mem [1024];
  exp_t exp_q [$];
  int req_cred = VC_LINK_CREDITS;
  int done_cnt = 0;
  int sent_cnt;
  logic started, bp_en;
  logic [31:0] stim_lfsr, hold_lfsr;
  int resp_cred, pending, hold_left;

  vc_tile DUT (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .my_cord_i(4'd7),
    .req_v_i(req_v_i), .req_op_i(req_op_i), .req_addr_i(req_addr_i),
    .req_data_i(req_data_i), .req_src_i(req_src_i), .req_credit_o(req_credit_o),
    .resp_v_o(resp_v_o), .resp_op_o(resp_op_o), .resp_data_o(resp_data_o),
    .resp_src_o(resp_src_o), .resp_credit_i(resp_credit_i),
    .wh_w_v_o(wh_w_v_o), .wh_w_flit_o(wh_w_flit_o), .wh_w_credit_i(wh_w_credit_i),
    .wh_w_v_i(wh_w_v_i), .wh_w_flit_i(wh_w_flit_i), .wh_w_credit_o(wh_w_credit_o),
    .wh_e_v_o(wh_e_v_o), .wh_e_flit_o(wh_e_flit_o), .wh_e_credit_i(wh_e_credit_i),
    .wh_e_v_i(wh_e_v_i), .wh_e_flit_i(wh_e_flit_i), .wh_e_credit_o(wh_e_credit_o)
  );

  tb_vc_mem #(.MY_CORD(VC_MEM_W_CORD), .IS_EAST(1'b0)) mem_w (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .v_i(wh_w_v_o), .flit_i(wh_w_flit_o),
    .credit_o(wh_w_credit_i), .v_o(wh_w_v_i), .flit_o(wh_w_flit_i),
    .credit_i(wh_w_credit_o), .err_o(mem_w_err)
  );

  tb_vc_mem #(.MY_CORD(VC_MEM_E_CORD), .IS_EAST(1'b1)) mem_e (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .v_i(wh_e_v_o), .flit_i(wh_e_flit_o),
    .credit_o(wh_e_credit_i), .v_o(wh_e_v_i), .flit_o(wh_e_flit_i),
    .credit_i(wh_e_credit_o), .err_o(mem_e_err)
  );

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // one galois LFSR step
  function automatic logic [31:0] lfsr_next(input logic [31:0] st);
    return st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
  endfunction

  // n bits drawn with one LFSR step per bit
  task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v  = {v[30:0], st[0]};
      st = lfsr_next(st);
    end
  endtask

  // waits for a request credit and then drives one request for one cycle
  task automatic send_req(input vc_op_e op, input logic [9:0] addr, input logic [31:0] data);
    exp_t e;
    while (req_cred + int'(req_credit_o) - int'(req_v_i) <= 0) begin
      req_v_i <= 1'b0;
      @(posedge clk_i);
    end
    started    <= 1'b1;
    req_v_i    <= 1'b1;
    req_op_i   <= op;
    req_addr_i <= addr;
    req_data_i <= data;
    req_src_i  <= VC_SRC_W'(sent_cnt);
    e.op   = op;
    e.src  = VC_SRC_W'(sent_cnt);
    e.data = (op == VC_OP_STORE) ? 32'd0 : ref_mem[addr];
    if (op == VC_OP_STORE) ref_mem[addr] = data;
    exp_q.push_back(e);
    sent_cnt++;
    @(posedge clk_i);
  endtask

  task automatic drain_all();
    req_v_i <= 1'b0;
    while (done_cnt < sent_cnt) @(posedge clk_i);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk_i);
    fail_now($sformatf("timeout: %0d of %0d responses after %0d cycles",
                       done_cnt, sent_cnt, WDOG_CYC));
  end

  // response checks, credit accounting and response credit return
  always @(posedge clk_i) begin
    exp_t e;
    logic [31:0] r;
    if (arst_n_i) begin
      if (!started) begin
        assert (!resp_v_o && !req_credit_o && !wh_w_v_o && !wh_e_v_o &&
                !wh_w_credit_o && !wh_e_credit_o)
          else fail_now("tile outputs active before the first request");
      end
      if (req_credit_o) begin
        assert (req_cred < VC_LINK_CREDITS)
          else fail_now("request credit returned with no request outstanding");
      end
      req_cred <= req_cred + int'(req_credit_o) - int'(req_v_i);
      assert (!mem_w_err && !mem_e_err) else fail_now("memory model reported an error");
      resp_cred = resp_cred + int'(resp_credit_i);
      resp_credit_i <= 1'b0;
      if (resp_v_o) begin
        assert (resp_cred > 0) else fail_now("response sent while tile held no credit");
        resp_cred = resp_cred - 1;
        assert (exp_q.size() > 0) else fail_now("response with no outstanding request");
        e = exp_q.pop_front();
        check_eq("resp_op_o", 32'(resp_op_o), 32'(e.op));
        check_eq("resp_src_o", 32'(resp_src_o), 32'(e.src));
        check_eq("resp_data_o", resp_data_o, e.data);
        pending++;
        done_cnt <= done_cnt + 1;
        if (bp_en && hold_left == 0) begin
          draw_bits(hold_lfsr, 3, r);
          if (r[2:0] == 3'd0) begin
            draw_bits(hold_lfsr, 5, r);
            hold_left = 10 + int'(r[4:0]);
          end
        end
      end
      if (hold_left > 0) begin
        hold_left--;
      end else if (pending > 0) begin
        resp_credit_i <= 1'b1;
        pending--;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [9:0] a;
    logic [4:0] tags [6];
    vc_op_e op;
    arst_n_i   = 1'b0;
    req_v_i    = 1'b0;
    req_op_i   = VC_OP_LOAD;
    req_addr_i = '0;
    req_data_i = '0;
    req_src_i  = '0;
    started    = 1'b0;
    bp_en      = 1'b0;
    sent_cnt   = 0;
    resp_cred  = VC_LINK_CREDITS;
    pending    = 0;
    hold_left  = 0;
    stim_lfsr  = 32'hec50;
    hold_lfsr  = 32'hec50;
    tags       = '{5'd0, 5'd1, 5'd2, 5'd16, 5'd17, 5'd18};
    for (int i = 0; i < 1024; i++) ref_mem[i] = {16'hc0de, 6'd0, 10'(i)};
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    repeat (6) @(posedge clk_i);

    // load of an untouched word then store and read back
    send_req(VC_OP_LOAD, 10'h3f1, 32'd0);
    send_req(VC_OP_STORE, 10'h3f1, 32'h1234_5678);
    send_req(VC_OP_LOAD, 10'h3f1, 32'd0);

    // six tags in one set on both sides force dirty evictions
    for (int t = 0; t < 6; t++) send_req(VC_OP_STORE, {tags[t], 3'd2, 2'd1}, 32'ha000_0000 + t);
    for (int t = 0; t < 6; t++) send_req(VC_OP_LOAD, {tags[t], 3'd2, 2'd1}, 32'd0);
    drain_all();
    for (int t = 0; t < 6; t++) begin
      for (int k = 0; k < 4; k++) begin
        a = {tags[t], 3'd2, 2'(k)};
        check_eq($sformatf("memory word %h", a),
                 a[9] ? mem_e.mem[a] : mem_w.mem[a], ref_mem[a]);
      end
    end

    // random mix with response credits withheld now and then
    bp_en <= 1'b1;
    for (int i = 0; i < 200; i++) begin
      draw_bits(stim_lfsr, 1, r);
      op = vc_op_e'(r[0]);
      draw_bits(stim_lfsr, 3, r);
      if (r[2:0] == 3'd0) begin
        draw_bits(stim_lfsr, 10, r);
        a = r[9:0];
      end else begin
        draw_bits(stim_lfsr, 8, r);
        a = {r[7:3], 2'b00, r[2:0]};
      end
      draw_bits(stim_lfsr, 32, r);
      send_req(op, a, r);
    end
    drain_all();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: flist.f
vc_pkg.sv
vc_credit_fifo.sv
vc_link_to_cache.sv
vc_cache.sv
vc_dma_to_wormhole.sv
vc_wh_router.sv
vc_tile.sv
tb_vc_mem.sv
tb_vc_tile.sv

// File: Makefile
SIM  := obj_dir/Vtb_vc_tile
SRCS := $(shell cat flist.f)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

$(SIM): flist.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_vc_tile -f flist.f

clean:
	rm -rf obj_dir
